/* filelist.f */
logic/io_bridge_pkg.sv
logic/os_timer.sv
logic/spi_byte_master.sv
logic/spi_port.sv
logic/bus_sequencer.sv
logic/io_bridge.sv
verification/io_bridge_tb.sv

/* Bender.yml */
package:
  name: io_bridge

sources:
  - logic/io_bridge_pkg.sv
  - logic/os_timer.sv
  - logic/spi_byte_master.sv
  - logic/spi_port.sv
  - logic/bus_sequencer.sv
  - logic/io_bridge.sv
  - target: simulation
    files:
      - verification/io_bridge_tb.sv

/* verification/io_bridge_tb.sv */
//==========================================================================
// Directed tests on the bridge top level with SPI miso looped back from mosi
// Bus outputs are sampled 1 time unit after the rising edge
//==========================================================================
module io_bridge_tb;
    import io_bridge_pkg::*;

    localparam int BUS_TIMEOUT   = 200;   // Cycles to wait for o_done
    localparam int TIMER_TIMEOUT = 100;   // Cycles to wait for an interrupt

    logic      clk = 1'b0;
    logic      reset;
    logic      i_start;
    bus_addr_t i_addr;
    bus_word_t i_data;
    logic      i_we;
    logic      i_boot_mode;
    bus_word_t o_q;
    logic      o_done;
    logic      o_timer1_int;
    logic      o_timer2_int;
    logic      o_spi0_clk;
    logic      o_spi0_cs;
    logic      o_spi0_mosi;
    logic      o_spi1_clk;
    logic      o_spi1_cs;
    logic      o_spi1_mosi;
    logic      i_spi0_miso;
    logic      i_spi1_miso;

    logic [31:0] lcg_state = 32'h8a0c;
    int          error_count = 0;
    int          tests_run = 0;
    int          tests_failed = 0;
    int          spi_clk_edges [2] = '{0, 0};
    int          timer_pulses [2] = '{0, 0};

    assign i_spi0_miso = o_spi0_mosi;  // Loopback
    assign i_spi1_miso = o_spi1_mosi;

    always #20 clk = ~clk;

    // Activity monitors
    always @(posedge o_spi0_clk) spi_clk_edges[0]++;
    always @(posedge o_spi1_clk) spi_clk_edges[1]++;
    always @(posedge o_timer1_int) timer_pulses[0]++;
    always @(posedge o_timer2_int) timer_pulses[1]++;

    io_bridge i_dut
    (
        .clk          (clk),
        .reset        (reset),
        .i_start      (i_start),
        .i_addr       (i_addr),
        .i_data       (i_data),
        .i_we         (i_we),
        .o_q          (o_q),
        .o_done       (o_done),
        .i_boot_mode  (i_boot_mode),
        .o_timer1_int (o_timer1_int),
        .o_timer2_int (o_timer2_int),
        .o_spi0_clk   (o_spi0_clk),
        .o_spi0_cs    (o_spi0_cs),
        .o_spi0_mosi  (o_spi0_mosi),
        .i_spi0_miso  (i_spi0_miso),
        .o_spi1_clk   (o_spi1_clk),
        .o_spi1_cs    (o_spi1_cs),
        .o_spi1_mosi  (o_spi1_mosi),
        .i_spi1_miso  (i_spi1_miso)
    );

    function automatic logic [31:0] next_random();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic port_cs(input int port);
        return (port == 1) ? o_spi1_cs : o_spi0_cs;
    endfunction

    function automatic logic port_clk(input int port);
        return (port == 1) ? o_spi1_clk : o_spi0_clk;
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string msg);
        if (actual !== expected)
        begin
            $display("Mismatch at %0t: %s, got %h, expected %h", $time, msg, actual, expected);
            error_count++;
        end
    endtask

    // One CPU access with start held for one clock
    task automatic bus_access(input bus_addr_t addr, input bus_word_t data, input logic we,
                              output bus_word_t q);
        int cycles;
        cycles = 0;
        @(posedge clk);
        #1;
        i_start = 1'b1;
        i_addr  = addr;
        i_data  = data;
        i_we    = we;
        @(posedge clk);
        #1;
        i_start = 1'b0;
        while (!o_done && cycles < BUS_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        q = o_q;
        if (!o_done)
        begin
            $display("Error at %0t: the bridge never signalled done for address %h",
                     $time, addr);
            error_count++;
        end
    endtask

    task automatic finish_test(input string name, input int errors_before);
        tests_run++;
        if (error_count == errors_before)
            $display("Test %-22s ok", name);
        else
        begin
            $display("Test %-22s failed", name);
            tests_failed++;
        end
    endtask

    //======================================================================
    // Tests
    //======================================================================
    task automatic reset_and_boot_test();
        bus_word_t q;
        int        errors_before;
        errors_before = error_count;
        check_value(o_done, 0, "done after reset");
        check_value(o_q, 0, "q after reset");
        check_value(o_timer1_int, 0, "timer 1 interrupt after reset");
        check_value(o_timer2_int, 0, "timer 2 interrupt after reset");
        check_value(o_spi0_cs, 1, "spi0 cs after reset");
        check_value(o_spi1_cs, 1, "spi1 cs after reset");
        check_value({o_spi0_clk, o_spi0_mosi, o_spi1_clk, o_spi1_mosi}, 0, "spi idle");
        i_boot_mode = 1'b1;
        bus_access(ADDR_BOOT_MODE, next_random(), 1'b0, q);
        check_value(q, 1, "boot mode 1");
        i_boot_mode = 1'b0;
        bus_access(ADDR_BOOT_MODE, next_random(), 1'b0, q);
        check_value(q, 0, "boot mode 0");
        finish_test("reset and boot mode", errors_before);
    endtask

    task automatic timer_test(input int which);
        bus_word_t q;
        int        value;
        int        cycles;
        int        other_before;
        int        errors_before;
        errors_before = error_count;
        value        = 5 + (next_random() >> 16) % 36;
        other_before = timer_pulses[2 - which];
        bus_access(which == 1 ? ADDR_TIMER1_VALUE : ADDR_TIMER2_VALUE, value, 1'b1, q);
        check_value(q, 0, "timer value write");
        bus_access(which == 1 ? ADDR_TIMER1_START : ADDR_TIMER2_START, 0, 1'b1, q);
        check_value(q, 0, "timer start write");
        cycles = 0;
        while (!(which == 1 ? o_timer1_int : o_timer2_int) && cycles < TIMER_TIMEOUT)
        begin
            @(posedge clk);
            #1;
            cycles++;
        end
        if (!(which == 1 ? o_timer1_int : o_timer2_int))
        begin
            $display("Error at %0t: timer %0d never raised its interrupt", $time, which);
            error_count++;
        end
        else
            // Trigger edge precedes done
            check_value(cycles, value - 1, "interrupt delay after done");
        @(posedge clk);
        #1;
        check_value(which == 1 ? o_timer1_int : o_timer2_int, 0, "interrupt is one cycle");
        repeat (4) @(posedge clk);
        check_value(timer_pulses[which - 1], 1, "single interrupt pulse");
        check_value(timer_pulses[2 - which], other_before, "other timer quiet");
        finish_test(which == 1 ? "timer 1" : "timer 2", errors_before);
    endtask

    task automatic spi_test(input int port);
        bus_addr_t data_addr;
        bus_addr_t cs_addr;
        bus_word_t q;
        bus_word_t data;
        int        edges_before;
        int        other_edges;
        logic      other_cs;
        int        errors_before;
        errors_before = error_count;
        data_addr   = (port == 1) ? ADDR_SPI1_DATA : ADDR_SPI0_DATA;
        cs_addr     = (port == 1) ? ADDR_SPI1_CS : ADDR_SPI0_CS;
        other_edges = spi_clk_edges[1 - port];
        other_cs    = port_cs(1 - port);

        bus_access(cs_addr, next_random() & ~32'd1, 1'b1, q);  // Only bit 0 counts
        check_value(q, 0, "cs write returns new cs");
        bus_access(cs_addr, next_random(), 1'b0, q);
        check_value(q, 0, "cs readback");
        check_value(port_cs(port), 0, "cs pin low");
        check_value(port_cs(1 - port), other_cs, "other port cs while cs low");

        for (int k = 0; k < 3; k++)
        begin
            data         = next_random();
            edges_before = spi_clk_edges[port];
            bus_access(data_addr, data, 1'b1, q);
            check_value(q, {24'd0, data[7:0]}, "looped back byte");
            check_value(spi_clk_edges[port] - edges_before, 8, "clock pulses per byte");
            check_value(port_clk(port), 0, "spi clock idles low");
        end

        edges_before = spi_clk_edges[port];
        bus_access(data_addr, next_random(), 1'b0, q);
        check_value(q, {24'd0, data[7:0]}, "data read holds last byte");
        check_value(spi_clk_edges[port] - edges_before, 0, "no clock on data read");

        bus_access(cs_addr, next_random() | 32'd1, 1'b1, q);
        check_value(q, 1, "cs write returns new cs");
        check_value(port_cs(port), 1, "cs pin high");
        check_value(spi_clk_edges[1 - port], other_edges, "other port clock idle");
        check_value(port_cs(1 - port), other_cs, "other port cs unchanged");
        finish_test(port == 1 ? "spi1" : "spi0", errors_before);
    endtask

    task automatic unmapped_test();
        bus_addr_t addrs [3] = '{32'h700000E, 32'h700001C, 32'h7FFFFFF};
        bus_word_t q;
        int        edges [2];
        int        pulses [2];
        int        errors_before;
        errors_before = error_count;
        edges  = spi_clk_edges;
        pulses = timer_pulses;
        foreach (addrs[i])
        begin
            // A stray cs write would pull a chip-select low
            bus_access(addrs[i], next_random() & ~32'd1, 1'b1, q);
            check_value(q, 0, $sformatf("write to %h", addrs[i]));
            bus_access(addrs[i], next_random(), 1'b0, q);
            check_value(q, 0, $sformatf("read from %h", addrs[i]));
        end
        check_value(spi_clk_edges[0] - edges[0], 0, "spi0 clock quiet");
        check_value(spi_clk_edges[1] - edges[1], 0, "spi1 clock quiet");
        check_value(timer_pulses[0] - pulses[0], 0, "timer 1 quiet");
        check_value(timer_pulses[1] - pulses[1], 0, "timer 2 quiet");
        check_value({o_spi0_cs, o_spi1_cs}, 2'b11, "chip-selects unchanged");
        finish_test("unmapped addresses", errors_before);
    endtask

    //======================================================================
    // Main sequence
    //======================================================================
    initial
    begin
        reset       = 1'b1;
        i_start     = 1'b0;
        i_addr      = '0;
        i_data      = '0;
        i_we        = 1'b0;
        i_boot_mode = 1'b0;
        repeat (5) @(posedge clk);
        #1;
        reset = 1'b0;

        reset_and_boot_test();
        timer_test(1);
        timer_test(2);
        spi_test(0);
        spi_test(1);
        unmapped_test();

        $display("Tests run %0d, tests failed %0d, errors %0d",
                 tests_run, tests_failed, error_count);
        if (error_count == 0)
            $display("Result: PASSED");
        else
            $display("Result: FAILED");
        $finish;
    end

endmodule

/* logic/io_bridge.sv */
//==========================================================================
// One access in flight; hold addr, data and we until done, no back-pressure
// SPI0 runs at clk / 2 and SPI1 at clk / 4, both mode 0
//==========================================================================
module io_bridge
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_start,
    input  io_bridge_pkg::bus_addr_t i_addr,
    input  io_bridge_pkg::bus_word_t i_data,
    input  logic                     i_we,
    output io_bridge_pkg::bus_word_t o_q,
    output logic                     o_done,
    input  logic                     i_boot_mode,
    output logic                     o_timer1_int,
    output logic                     o_timer2_int,
    output logic                     o_spi0_clk,
    output logic                     o_spi0_cs,
    output logic                     o_spi0_mosi,
    input  logic                     i_spi0_miso,
    output logic                     o_spi1_clk,
    output logic                     o_spi1_cs,
    output logic                     o_spi1_mosi,
    input  logic                     i_spi1_miso
);
    import io_bridge_pkg::*;

    logic         timer1_set;
    logic         timer1_trigger;
    logic         timer2_set;
    logic         timer2_trigger;
    timer_count_t timer_value;    // Shared by both timers
    logic         spi0_start;
    logic         spi1_start;
    spi_byte_t    spi_tx_byte;    // Shared by both ports
    logic         spi0_cs_we;
    logic         spi1_cs_we;
    logic         spi_cs_value;
    spi_byte_t    spi0_rx_byte;
    spi_byte_t    spi1_rx_byte;
    logic         spi0_done;
    logic         spi1_done;

    bus_sequencer i_sequencer
    (
        .clk              (clk),
        .reset            (reset),
        .i_start          (i_start),
        .i_addr           (i_addr),
        .i_data           (i_data),
        .i_we             (i_we),
        .i_boot_mode      (i_boot_mode),
        .o_q              (o_q),
        .o_done           (o_done),
        .o_timer1_set     (timer1_set),
        .o_timer1_trigger (timer1_trigger),
        .o_timer2_set     (timer2_set),
        .o_timer2_trigger (timer2_trigger),
        .o_timer_value    (timer_value),
        .o_spi0_start     (spi0_start),
        .o_spi1_start     (spi1_start),
        .o_spi_tx_byte    (spi_tx_byte),
        .o_spi0_cs_we     (spi0_cs_we),
        .o_spi1_cs_we     (spi1_cs_we),
        .o_spi_cs_value   (spi_cs_value),
        .i_spi0_cs        (o_spi0_cs),
        .i_spi1_cs        (o_spi1_cs),
        .i_spi0_rx_byte   (spi0_rx_byte),
        .i_spi1_rx_byte   (spi1_rx_byte),
        .i_spi0_done      (spi0_done),
        .i_spi1_done      (spi1_done)
    );

    //======================================================================
    // Peripherals
    //======================================================================
    os_timer i_timer1
    (
        .clk         (clk),
        .reset       (reset),
        .i_set       (timer1_set),
        .i_value     (timer_value),
        .i_trigger   (timer1_trigger),
        .o_interrupt (o_timer1_int)
    );

    os_timer i_timer2
    (
        .clk         (clk),
        .reset       (reset),
        .i_set       (timer2_set),
        .i_value     (timer_value),
        .i_trigger   (timer2_trigger),
        .o_interrupt (o_timer2_int)
    );

    spi_port #(.CLKS_PER_HALF_BIT (SPI_FAST_HALF_BIT)) i_spi0
    (
        .clk          (clk),
        .reset        (reset),
        .i_data_start (spi0_start),
        .i_tx_byte    (spi_tx_byte),
        .i_cs_we      (spi0_cs_we),
        .i_cs_value   (spi_cs_value),
        .i_miso       (i_spi0_miso),
        .o_cs         (o_spi0_cs),
        .o_rx_byte    (spi0_rx_byte),
        .o_done       (spi0_done),
        .o_spi_clk    (o_spi0_clk),
        .o_mosi       (o_spi0_mosi)
    );

    spi_port #(.CLKS_PER_HALF_BIT (SPI_SLOW_HALF_BIT)) i_spi1
    (
        .clk          (clk),
        .reset        (reset),
        .i_data_start (spi1_start),
        .i_tx_byte    (spi_tx_byte),
        .i_cs_we      (spi1_cs_we),
        .i_cs_value   (spi_cs_value),
        .i_miso       (i_spi1_miso),
        .o_cs         (o_spi1_cs),
        .o_rx_byte    (spi1_rx_byte),
        .o_done       (spi1_done),
        .o_spi_clk    (o_spi1_clk),
        .o_mosi       (o_spi1_mosi)
    );

endmodule

/* logic/bus_sequencer.sv */
//==========================================================================
// i_start is only looked at in IDLE; fixed accesses finish 2 clocks later
// An SPI data write finishes one clock after the port reports done
//==========================================================================
module bus_sequencer
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_start,
    input  io_bridge_pkg::bus_addr_t    i_addr,
    input  io_bridge_pkg::bus_word_t    i_data,
    input  logic                        i_we,
    input  logic                        i_boot_mode,
    output io_bridge_pkg::bus_word_t    o_q,
    output logic                        o_done,
    output logic                        o_timer1_set,
    output logic                        o_timer1_trigger,
    output logic                        o_timer2_set,
    output logic                        o_timer2_trigger,
    output io_bridge_pkg::timer_count_t o_timer_value,
    output logic                        o_spi0_start,
    output logic                        o_spi1_start,
    output io_bridge_pkg::spi_byte_t    o_spi_tx_byte,
    output logic                        o_spi0_cs_we,
    output logic                        o_spi1_cs_we,
    output logic                        o_spi_cs_value,
    input  logic                        i_spi0_cs,
    input  logic                        i_spi1_cs,
    input  io_bridge_pkg::spi_byte_t    i_spi0_rx_byte,
    input  io_bridge_pkg::spi_byte_t    i_spi1_rx_byte,
    input  logic                        i_spi0_done,
    input  logic                        i_spi1_done
);
    import io_bridge_pkg::*;

    bus_state_e state;
    logic       settle;       // First cycle after IDLE, lets cs writes land
    logic       spi_sel;      // 0 = SPI0, 1 = SPI1
    logic       spi_pending;  // Waiting on a transfer

    logic       addr_spi1;
    logic       sel_done;
    logic       sel_cs;
    spi_byte_t  sel_rx;

    assign addr_spi1 = (i_addr == ADDR_SPI1_DATA) || (i_addr == ADDR_SPI1_CS);
    assign sel_done  = spi_sel ? i_spi1_done : i_spi0_done;
    assign sel_cs    = spi_sel ? i_spi1_cs : i_spi0_cs;
    assign sel_rx    = spi_sel ? i_spi1_rx_byte : i_spi0_rx_byte;

    // Command payloads, only meaningful alongside their strobes
    always_ff @(posedge clk)
    begin
        if (state == IDLE && i_start)
        begin
            o_timer_value  <= i_data;
            o_spi_tx_byte  <= i_data[7:0];
            o_spi_cs_value <= i_data[0];
        end
    end

    //======================================================================
    // Access FSM
    //======================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state            <= IDLE;
            settle           <= 1'b0;
            spi_sel          <= 1'b0;
            spi_pending      <= 1'b0;
            o_q              <= '0;
            o_done           <= 1'b0;
            o_timer1_set     <= 1'b0;
            o_timer1_trigger <= 1'b0;
            o_timer2_set     <= 1'b0;
            o_timer2_trigger <= 1'b0;
            o_spi0_start     <= 1'b0;
            o_spi1_start     <= 1'b0;
            o_spi0_cs_we     <= 1'b0;
            o_spi1_cs_we     <= 1'b0;
        end
        else
        begin
            // Strobes are single cycle
            o_q              <= '0;
            o_done           <= 1'b0;
            settle           <= 1'b0;
            o_timer1_set     <= 1'b0;
            o_timer1_trigger <= 1'b0;
            o_timer2_set     <= 1'b0;
            o_timer2_trigger <= 1'b0;
            o_spi0_start     <= 1'b0;
            o_spi1_start     <= 1'b0;
            o_spi0_cs_we     <= 1'b0;
            o_spi1_cs_we     <= 1'b0;

            case (state)
                IDLE:
                begin
                    if (i_start)
                    begin
                        settle <= 1'b1;
                        state  <= RETURN_ZERO;  // Unless decoded below
                        case (i_addr)
                            ADDR_TIMER1_VALUE: o_timer1_set     <= 1'b1;
                            ADDR_TIMER1_START: o_timer1_trigger <= 1'b1;
                            ADDR_TIMER2_VALUE: o_timer2_set     <= 1'b1;
                            ADDR_TIMER2_START: o_timer2_trigger <= 1'b1;
                            ADDR_SPI0_DATA, ADDR_SPI1_DATA:
                            begin
                                spi_sel      <= addr_spi1;
                                spi_pending  <= i_we;
                                o_spi0_start <= i_we && !addr_spi1;
                                o_spi1_start <= i_we && addr_spi1;
                                state        <= WAIT_SPI_DATA;
                            end
                            ADDR_SPI0_CS, ADDR_SPI1_CS:
                            begin
                                spi_sel      <= addr_spi1;
                                o_spi0_cs_we <= i_we && !addr_spi1;
                                o_spi1_cs_we <= i_we && addr_spi1;
                                state        <= READ_SPI_CS;
                            end
                            ADDR_BOOT_MODE: state <= READ_BOOT_MODE;
                            default: ;  // Reserved and out of range read zero
                        endcase
                    end
                end

                RETURN_ZERO:
                begin
                    if (!settle)
                    begin
                        o_done <= 1'b1;
                        state  <= IDLE;
                    end
                end

                WAIT_SPI_DATA:
                begin
                    // A read just returns the byte held from the last transfer
                    if (spi_pending ? sel_done : !settle)
                    begin
                        o_done      <= 1'b1;
                        o_q         <= {24'd0, sel_rx};
                        spi_pending <= 1'b0;
                        state       <= IDLE;
                    end
                end

                READ_SPI_CS:
                begin
                    if (!settle)
                    begin
                        o_done <= 1'b1;
                        o_q    <= {31'd0, sel_cs};
                        state  <= IDLE;
                    end
                end

                READ_BOOT_MODE:
                begin
                    if (!settle)
                    begin
                        o_done <= 1'b1;
                        o_q    <= {31'd0, i_boot_mode};
                        state  <= IDLE;
                    end
                end

                default: state <= IDLE;
            endcase
        end
    end

endmodule

/* logic/spi_port.sv */
//==========================================================================
// Chip-select is CPU driven only; a transfer never touches it
// cs resets high (deselected) and updates on the edge after the write
//==========================================================================
module spi_port
#(
    parameter int CLKS_PER_HALF_BIT = 1
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_data_start,
    input  io_bridge_pkg::spi_byte_t i_tx_byte,
    input  logic                     i_cs_we,
    input  logic                     i_cs_value,
    input  logic                     i_miso,
    output logic                     o_cs,
    output io_bridge_pkg::spi_byte_t o_rx_byte,
    output logic                     o_done,
    output logic                     o_spi_clk,
    output logic                     o_mosi
);

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            o_cs <= 1'b1;
        end
        else if (i_cs_we)
        begin
            o_cs <= i_cs_value;
        end
    end

    spi_byte_master
    #(
        .CLKS_PER_HALF_BIT (CLKS_PER_HALF_BIT)
    )
    i_shifter
    (
        .clk       (clk),
        .reset     (reset),
        .i_start   (i_data_start),
        .i_tx_byte (i_tx_byte),
        .i_miso    (i_miso),
        .o_done    (o_done),
        .o_rx_byte (o_rx_byte),
        .o_spi_clk (o_spi_clk),
        .o_mosi    (o_mosi)
    );

endmodule

/* logic/spi_byte_master.sv */
//==========================================================================
// SPI mode 0, one byte MSB first, 16 * CLKS_PER_HALF_BIT clocks per byte
// CLKS_PER_HALF_BIT must be 1 or more; start is ignored while busy
//==========================================================================
module spi_byte_master
#(
    parameter int CLKS_PER_HALF_BIT = 1
)
(
    input  logic                     clk,
    input  logic                     reset,
    input  logic                     i_start,
    input  io_bridge_pkg::spi_byte_t i_tx_byte,
    input  logic                     i_miso,
    output logic                     o_done,
    output io_bridge_pkg::spi_byte_t o_rx_byte,
    output logic                     o_spi_clk,
    output logic                     o_mosi
);
    import io_bridge_pkg::*;

    localparam int DIV_W = $clog2(CLKS_PER_HALF_BIT + 1);

    logic [DIV_W-1:0] div_count;   // Clocks within the half bit
    logic [4:0]       edges_left;  // SPI clock edges still to go
    logic             busy;
    spi_byte_t        shift_reg;
    logic             miso_bit;    // Sampled on the rising edge

    logic half_tick;
    logic rise;
    logic fall;
    logic last_fall;

    assign half_tick = busy && div_count == DIV_W'(CLKS_PER_HALF_BIT - 1);
    assign rise      = half_tick && !o_spi_clk;
    assign fall      = half_tick && o_spi_clk;
    assign last_fall = fall && edges_left == 5'd1;

    //======================================================================
    // Clock generation and control
    //======================================================================
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            div_count  <= '0;
            edges_left <= '0;
            o_spi_clk  <= 1'b0;
            o_mosi     <= 1'b0;
            o_done     <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (!busy)
            begin
                if (i_start)
                begin
                    busy       <= 1'b1;
                    div_count  <= '0;
                    edges_left <= 5'd16;
                    o_mosi     <= i_tx_byte[7];  // MSB ready before first rise
                end
            end
            else if (half_tick)
            begin
                div_count  <= '0;
                o_spi_clk  <= ~o_spi_clk;
                edges_left <= edges_left - 1'b1;
                if (last_fall)
                begin
                    busy   <= 1'b0;
                    o_done <= 1'b1;
                    o_mosi <= 1'b0;
                end
                else if (fall)
                begin
                    o_mosi <= shift_reg[6];  // Next bit out
                end
            end
            else
            begin
                div_count <= div_count + 1'b1;
            end
        end
    end

    // Shared shift register, tx bits leave at the top as rx bits enter below
    always_ff @(posedge clk)
    begin
        if (!busy && i_start)
        begin
            shift_reg <= i_tx_byte;
        end
        else if (fall)
        begin
            shift_reg <= {shift_reg[6:0], miso_bit};
        end

        if (rise)
        begin
            miso_bit <= i_miso;
        end

        if (last_fall)
        begin
            o_rx_byte <= {shift_reg[6:0], miso_bit};  // Held until next byte
        end
    end

endmodule

/* logic/os_timer.sv */
//==========================================================================
// One-shot timer. A trigger while running restarts the count from reload
// A reload value of 0 fires on the cycle after the trigger
//==========================================================================
module os_timer
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        i_set,
    input  io_bridge_pkg::timer_count_t i_value,
    input  logic                        i_trigger,
    output logic                        o_interrupt
);
    import io_bridge_pkg::*;

    timer_count_t reload;
    timer_count_t count;
    logic         running;

    // Reload value and countdown
    always_ff @(posedge clk)
    begin
        if (i_set)
        begin
            reload <= i_value;
        end

        if (i_trigger)
        begin
            count <= reload;
        end
        else if (running && count != '0)
        begin
            count <= count - 1'b1;
        end
    end

    // Run flag and expiry pulse
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            running     <= 1'b0;
            o_interrupt <= 1'b0;
        end
        else
        begin
            o_interrupt <= 1'b0;
            if (i_trigger)
            begin
                running <= 1'b1;
            end
            else if (running && count <= timer_count_t'(1))
            begin
                running     <= 1'b0;  // One shot, stop here
                o_interrupt <= 1'b1;
            end
        end
    end

endmodule

/* logic/io_bridge_pkg.sv */
//==========================================================================
// Word addresses in the 0x7000000 I/O window; unmapped words read as zero
// SPI speeds are clocks per half bit, so the SPI rate is clk / (2 * n)
//==========================================================================
package io_bridge_pkg;

    //======================================================================
    // Data types
    //======================================================================
    typedef logic [31:0] bus_word_t;     // CPU data word
    typedef logic [31:0] bus_addr_t;     // CPU address in words
    typedef logic [31:0] timer_count_t;  // Timer reload and count, in clocks
    typedef logic [7:0]  spi_byte_t;     // One SPI transfer

    //======================================================================
    // Address map
    //======================================================================
    // OS timers
    localparam bus_addr_t ADDR_TIMER1_VALUE = 32'h7000002;
    localparam bus_addr_t ADDR_TIMER1_START = 32'h7000003;
    localparam bus_addr_t ADDR_TIMER2_VALUE = 32'h7000004;
    localparam bus_addr_t ADDR_TIMER2_START = 32'h7000005;

    // SPI ports, data and chip-select per port
    localparam bus_addr_t ADDR_SPI0_DATA    = 32'h7000008;
    localparam bus_addr_t ADDR_SPI0_CS      = 32'h7000009;
    localparam bus_addr_t ADDR_SPI1_DATA    = 32'h700000A;
    localparam bus_addr_t ADDR_SPI1_CS      = 32'h700000B;

    localparam bus_addr_t ADDR_BOOT_MODE    = 32'h7000019;  // Read only

    //======================================================================
    // SPI speeds
    //======================================================================
    localparam int SPI_FAST_HALF_BIT = 1;  // Port 0, clk / 2
    localparam int SPI_SLOW_HALF_BIT = 2;  // Port 1, clk / 4

    //======================================================================
    // Sequencer states
    //======================================================================
    // SPI states serve both ports; the port is picked by a select register
    typedef enum logic [2:0]
    {
        IDLE,
        RETURN_ZERO,
        WAIT_SPI_DATA,
        READ_SPI_CS,
        READ_BOOT_MODE
    } bus_state_e;

endpackage
